// ==== common/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch address width
`define ADDR_W 32

// one fetched word
`define XLEN 64

// sets per way
`define SETS 64

// 64-bit beats per cache line
`define BEATS 4

// top address nibble of the uncached region
`define UNCACHED_NIBBLE 4'd3

`endif

// ==== common/icachePkg.sv ====
`include "icache_defs.svh"

package icachePkg;

  // one address word, seen flat or split into cache fields
  // 21 + 6 + 5 bits make up the 32-bit address
  typedef union packed {
    logic [`ADDR_W-1:0] word;
    struct packed {
      logic [20:0] tag;
      logic [5:0]  index;
      logic [4:0]  offset;
    } f;
  } fetchAddr_u;

  // last request taken from the fetch stage
  typedef struct packed {
    fetchAddr_u addr;
    logic       uncached;
  } fetchReq_s;

  // line collected from memory
  // done pulses with the last beat, line is complete from the next cycle on
  typedef struct packed {
    logic [`BEATS*`XLEN-1:0] line;
    logic                    done;
  } lineFill_s;

endpackage

// ==== verilog/fetchReqLatch.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module fetchReqLatch (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`ADDR_W-1:0]   addr_i,
  input  logic                 valid_i,
  input  logic                 takeReq_i,
  output icachePkg::fetchReq_s req_o,
  output logic                 reqNew_o
);

  icachePkg::fetchReq_s reqQ;
  logic                 heldValid;

  // held request, replaced only when the controller takes a new one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqQ      <= '0;
      heldValid <= 1'b0;
    end else if (takeReq_i) begin
      reqQ.addr.word <= addr_i;
      reqQ.uncached  <= (addr_i[`ADDR_W-1 -: 4] == `UNCACHED_NIBBLE);
      heldValid      <= 1'b1;
    end
  end

  // same pc presented again is not fetched twice
  // before the first take any valid address counts as new
  assign reqNew_o = valid_i && (!heldValid || (addr_i != reqQ.addr.word));

  assign req_o = reqQ;

endmodule

// ==== icache/icacheCtrl.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheCtrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  icachePkg::fetchReq_s    req_i,
  input  logic                    reqNew_i,
  input  logic                    valid_i,
  input  logic                    stall_n_i,
  input  logic                    hitWay1_i,
  input  logic                    hitWay2_i,
  input  icachePkg::lineFill_s    fill_i,
  input  logic [`BEATS*`XLEN-1:0] way1Word_i,
  input  logic [`BEATS*`XLEN-1:0] way2Word_i,
  input  logic                    axiRdReady_i,
  output logic                    takeReq_o,
  output logic                    tagWrite_o,
  output logic                    lineWrite_o,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output logic                    dataNotOk_o,
  output logic [`XLEN-1:0]        rdData_o,
  output logic                    cacheRdValid_o,
  output logic [`ADDR_W-1:0]      cacheAddr_o,
  output logic [7:0]              fetchLen_o
);

  localparam logic [2:0] StIdle    = 3'b000;
  localparam logic [2:0] StCompare = 3'b001;
  localparam logic [2:0] StMiss    = 3'b010;
  localparam logic [2:0] StGetData = 3'b011;
  localparam logic [2:0] StReplace = 3'b111;

  logic [2:0]              curState;
  logic [2:0]              nxtState;
  logic                    cacheHit;
  logic                    uncachedDone;
  logic                    holdUncached;
  logic                    fillBypass;
  logic [1:0]              wordSel;
  logic [`BEATS*`XLEN-1:0] srcLine;

  // uncached requests never hit the arrays, only the finished single beat
  assign cacheHit = req_i.uncached ? uncachedDone : (hitWay1_i || hitWay2_i);
  assign holdUncached = req_i.uncached && uncachedDone && !stall_n_i;

  assign addrOk_o  = (curState == StIdle) || ((curState == StCompare) && cacheHit);
  assign takeReq_o = addrOk_o && valid_i && reqNew_i && stall_n_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= StIdle;
    end else begin
      curState <= nxtState;
    end
  end

  always_comb begin
    nxtState = curState;
    case (curState)
      StIdle: begin
        if (takeReq_o) begin
          nxtState = StCompare;
        end
      end
      StCompare: begin
        if (!cacheHit) begin
          nxtState = StMiss;
        end else if (takeReq_o || holdUncached) begin
          nxtState = StCompare;
        end else begin
          nxtState = StIdle;
        end
      end
      // memory back-pressure point
      StMiss: begin
        if (axiRdReady_i) begin
          nxtState = StGetData;
        end
      end
      StGetData: begin
        if (fill_i.done) begin
          nxtState = req_i.uncached ? StCompare : StReplace;
        end
      end
      StReplace: begin
        nxtState = StCompare;
      end
      default: begin
        nxtState = StIdle;
      end
    endcase
  end

  // uncached beat stays valid until the pipeline moves on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uncachedDone <= 1'b0;
    end else if ((curState == StGetData) && fill_i.done && req_i.uncached) begin
      uncachedDone <= 1'b1;
    end else if (stall_n_i) begin
      uncachedDone <= 1'b0;
    end
  end

  // ram read in replace still returns the old line, so take the fill buffer once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fillBypass <= 1'b0;
    end else begin
      fillBypass <= (curState == StReplace);
    end
  end

  assign wordSel = req_i.addr.f.offset[4:3];
  assign srcLine = fillBypass ? fill_i.line : (hitWay2_i ? way2Word_i : way1Word_i);
  assign rdData_o = req_i.uncached ? fill_i.line[`XLEN-1:0]
                                   : srcLine[wordSel*`XLEN +: `XLEN];

  assign dataOk_o    = (curState == StCompare) && cacheHit;
  assign dataNotOk_o = ((curState == StCompare) && !cacheHit) || (curState == StMiss) ||
                       (curState == StGetData) || (curState == StReplace);

  // line and tag are written together in the one replace cycle
  assign tagWrite_o  = (curState == StReplace);
  assign lineWrite_o = (curState == StReplace);

  assign cacheRdValid_o = (curState == StMiss) && axiRdReady_i;
  assign cacheAddr_o    = req_i.uncached ? req_i.addr.word
                                         : {req_i.addr.f.tag, req_i.addr.f.index, 5'b0};
  assign fetchLen_o     = req_i.uncached ? 8'd0 : 8'(`BEATS - 1);

endmodule

// ==== icache/icacheTagStore.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheTagStore (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  icachePkg::fetchAddr_u addr_i,
  input  logic                  tagWrite_i,
  output logic                  hitWay1_o,
  output logic                  hitWay2_o,
  output logic                  victim_o
);

  localparam int IdxW = $clog2(`SETS);
  localparam int TagW = `ADDR_W - IdxW - 5;

  logic victimQ;

  for (genvar w = 0; w < 2; w++) begin : gWay
    localparam logic WayId = 1'(w);

    logic [TagW-1:0]  tagArr [`SETS];
    logic [`SETS-1:0] validQ;
    logic             wrEn;
    logic             hit;

    assign wrEn = tagWrite_i && (victimQ == WayId);

    // flush takes priority over a refill in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        validQ <= '0;
      end else if (flush_i) begin
        validQ <= '0;
      end else if (wrEn) begin
        validQ[addr_i.f.index] <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (wrEn) begin
        tagArr[addr_i.f.index] <= addr_i.f.tag;
      end
    end

    assign hit = validQ[addr_i.f.index] && (tagArr[addr_i.f.index] == addr_i.f.tag);
  end

  // victim alternates after every refill, way 1 first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimQ <= 1'b0;
    end else if (tagWrite_i) begin
      victimQ <= ~victimQ;
    end
  end

  assign hitWay1_o = gWay[0].hit;
  assign hitWay2_o = gWay[1].hit;
  assign victim_o  = victimQ;

endmodule

// ==== icache/icacheDataStore.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheDataStore (
  input  logic                    clk,
  input  logic [5:0]              rdIndex_i,
  input  logic [5:0]              wrIndex_i,
  input  logic                    lineWrite_i,
  input  logic                    victim_i,
  input  icachePkg::lineFill_s    fill_i,
  output logic [`BEATS*`XLEN-1:0] way1Word_o,
  output logic [`BEATS*`XLEN-1:0] way2Word_o
);

  localparam int LineW = `BEATS * `XLEN;

  for (genvar w = 0; w < 2; w++) begin : gWay
    localparam logic WayId = 1'(w);

    logic [LineW-1:0] ram [`SETS];
    logic [LineW-1:0] rdQ;

    // read every cycle, old contents on a same-index write
    always_ff @(posedge clk) begin
      if (lineWrite_i && (victim_i == WayId)) begin
        ram[wrIndex_i] <= fill_i.line;
      end
      rdQ <= ram[rdIndex_i];
    end
  end

  assign way1Word_o = gWay[0].rdQ;
  assign way2Word_o = gWay[1].rdQ;

endmodule

// ==== verilog/refillBuffer.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module refillBuffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 collect_i,
  input  logic [`XLEN-1:0]     rdData_i,
  input  logic                 dataValid_i,
  input  logic                 rdLast_i,
  output icachePkg::lineFill_s fill_o
);

  logic [$clog2(`BEATS)-1:0] beatCnt;
  logic [`BEATS*`XLEN-1:0]   lineQ;
  logic                      beatTake;

  // beats only count while a miss is open
  assign beatTake = collect_i && dataValid_i;

  // back to slot 0 after the last beat, so a single uncached beat lands low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      if (rdLast_i) begin
        beatCnt <= '0;
      end else begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineQ[beatCnt*`XLEN +: `XLEN] <= rdData_i;
    end
  end

  assign fill_o.line = lineQ;
  assign fill_o.done = beatTake && rdLast_i;

endmodule

// ==== verilog/icacheTop.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheTop (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  input  logic [`ADDR_W-1:0] addr_i,
  input  logic               valid_i,
  input  logic               stall_n_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output logic               dataNotOk_o,
  output logic [`XLEN-1:0]   rdData_o,
  output logic               cacheRdValid_o,
  output logic [`ADDR_W-1:0] cacheAddr_o,
  output logic [7:0]         fetchLen_o,
  input  logic               axiRdReady_i,
  input  logic [`XLEN-1:0]   rdData_i,
  input  logic               dataValid_i,
  input  logic               rdLast_i
);

  icachePkg::fetchReq_s    req;
  icachePkg::fetchAddr_u   inAddr;
  icachePkg::lineFill_s    fill;
  logic                    reqNew;
  logic                    takeReq;
  logic                    hitWay1;
  logic                    hitWay2;
  logic                    victim;
  logic                    tagWrite;
  logic                    lineWrite;
  logic [5:0]              rdIndex;
  logic [`BEATS*`XLEN-1:0] way1Word;
  logic [`BEATS*`XLEN-1:0] way2Word;

  assign inAddr = addr_i;
  // ram read leads the compare by one cycle
  assign rdIndex = takeReq ? inAddr.f.index : req.addr.f.index;

  fetchReqLatch u_reqLatch (
    .clk(clk), .rst_n(rst_n), .addr_i(addr_i), .valid_i(valid_i),
    .takeReq_i(takeReq), .req_o(req), .reqNew_o(reqNew)
  );

  icacheCtrl u_ctrl (
    .clk(clk), .rst_n(rst_n), .req_i(req), .reqNew_i(reqNew), .valid_i(valid_i),
    .stall_n_i(stall_n_i), .hitWay1_i(hitWay1), .hitWay2_i(hitWay2), .fill_i(fill),
    .way1Word_i(way1Word), .way2Word_i(way2Word), .axiRdReady_i(axiRdReady_i),
    .takeReq_o(takeReq), .tagWrite_o(tagWrite), .lineWrite_o(lineWrite),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .dataNotOk_o(dataNotOk_o),
    .rdData_o(rdData_o), .cacheRdValid_o(cacheRdValid_o), .cacheAddr_o(cacheAddr_o),
    .fetchLen_o(fetchLen_o)
  );

  icacheTagStore u_tagStore (
    .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .addr_i(req.addr),
    .tagWrite_i(tagWrite), .hitWay1_o(hitWay1), .hitWay2_o(hitWay2), .victim_o(victim)
  );

  icacheDataStore u_dataStore (
    .clk(clk), .rdIndex_i(rdIndex), .wrIndex_i(req.addr.f.index),
    .lineWrite_i(lineWrite), .victim_i(victim), .fill_i(fill),
    .way1Word_o(way1Word), .way2Word_o(way2Word)
  );

  // a miss is open exactly while data is flagged not ok
  refillBuffer u_refill (
    .clk(clk), .rst_n(rst_n), .collect_i(dataNotOk_o), .rdData_i(rdData_i),
    .dataValid_i(dataValid_i), .rdLast_i(rdLast_i), .fill_o(fill)
  );

endmodule

// ==== verification/icacheProps.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheProps (
  input logic               clk,
  input logic               rst_n,
  input logic               cacheRdValid_i,
  input logic               dataOk_i,
  input logic               dataNotOk_i,
  input logic [`ADDR_W-1:0] cacheAddr_i,
  input logic [7:0]         fetchLen_i
);

  // read request is a single-cycle pulse
  rdValidPulse: assert property (
    @(posedge clk) disable iff (!rst_n) cacheRdValid_i |=> !cacheRdValid_i
  ) else $error("cacheRdValid_o high for more than one cycle");

  // a miss stays flagged until its word is returned
  notOkUntilOk: assert property (
    @(posedge clk) disable iff (!rst_n) dataNotOk_i |=> (dataNotOk_i || dataOk_i)
  ) else $error("dataNotOk_o dropped before dataOk_o");

  // uncached reads are single beats and cached reads aligned lines
  burstShape: assert property (
    @(posedge clk) disable iff (!rst_n)
    cacheRdValid_i |-> ((cacheAddr_i[`ADDR_W-1 -: 4] == `UNCACHED_NIBBLE) ?
                        (fetchLen_i == 8'd0) :
                        (fetchLen_i == 8'd3 && cacheAddr_i[4:0] == 5'd0))
  ) else $error("read burst length or alignment does not match the address region");

endmodule

bind icacheTop icacheProps u_props (
  .clk(clk), .rst_n(rst_n), .cacheRdValid_i(cacheRdValid_o), .dataOk_i(dataOk_o),
  .dataNotOk_i(dataNotOk_o), .cacheAddr_i(cacheAddr_o), .fetchLen_i(fetchLen_o)
);

// ==== verification/icacheTb.sv ====
`timescale 1ns/1ns
`include "icache_defs.svh"

module icacheTb;

  // 20 fetches, each far below 1000 cycles even with slow memory
  localparam int MaxCycles = 20000;
  localparam logic [`ADDR_W-1:0] LineL = 32'h0000_1000;
  // P, Q and R share set 5
  localparam logic [`ADDR_W-1:0] LineP = 32'h0000_08A0;
  localparam logic [`ADDR_W-1:0] LineQ = 32'h0000_10A0;
  localparam logic [`ADDR_W-1:0] LineR = 32'h0000_18A0;
  localparam logic [`ADDR_W-1:0] LineS = 32'h0000_4440;
  localparam logic [`ADDR_W-1:0] UncAddr = 32'h3000_0100;

  logic               clk = 1'b0;
  logic               rst_n = 1'b0;
  logic               flush_i = 1'b0;
  logic [`ADDR_W-1:0] addr_i = '0;
  logic               valid_i = 1'b0;
  logic               stall_n_i = 1'b1;
  logic               axiRdReady_i = 1'b0;
  logic [`XLEN-1:0]   rdData_i = '0;
  logic               dataValid_i = 1'b0;
  logic               rdLast_i = 1'b0;
  logic               addrOk_o;
  logic               dataOk_o;
  logic               dataNotOk_o;
  logic               cacheRdValid_o;
  logic [`XLEN-1:0]   rdData_o;
  logic [`ADDR_W-1:0] cacheAddr_o;
  logic [7:0]         fetchLen_o;

  integer             seed = 44;
  int                 cycleCnt = 0;
  int                 checkCount = 0;
  int                 errCount = 0;
  int                 errAtStart = 0;
  int                 reqCount = 0;
  int                 fillCount = 0;
  int                 beatsLeft = 0;
  logic               memBusy = 1'b0;
  logic [`ADDR_W-1:0] lastReqAddr = '0;
  logic [`ADDR_W-1:0] beatAddr = '0;
  logic [`ADDR_W-1:0] takenAddr = '1;
  logic [7:0]         lastReqLen = '0;

  always #5 clk = ~clk;

  icacheTop icacheTop_i (.*);

  // word address in the high half, its inverse in the low half
  function automatic logic [`XLEN-1:0] refWord(input logic [`ADDR_W-1:0] addr);
    logic [`ADDR_W-1:0] wordAddr;
    wordAddr = {addr[`ADDR_W-1:3], 3'b000};
    return {wordAddr, ~wordAddr};
  endfunction

  // memory answers each read pulse with fetchLen_o + 1 beats, random gaps
  always @(posedge clk) begin
    int rnd;
    rnd = $random(seed);
    if (!memBusy) begin
      dataValid_i  <= 1'b0;
      rdLast_i     <= 1'b0;
      axiRdReady_i <= rst_n && (rnd[1:0] != 2'b00);
      if (rst_n && cacheRdValid_o) begin
        memBusy      = 1'b1;
        reqCount++;
        lastReqAddr  = cacheAddr_o;
        lastReqLen   = fetchLen_o;
        beatAddr     = cacheAddr_o;
        beatsLeft    = int'(fetchLen_o) + 1;
        axiRdReady_i <= 1'b0;
      end
    end else if (rnd[3:2] == 2'b00) begin
      dataValid_i <= 1'b0;
    end else begin
      dataValid_i <= 1'b1;
      rdData_i    <= refWord(beatAddr);
      rdLast_i    <= (beatsLeft == 1);
      beatAddr    = beatAddr + 32'd8;
      beatsLeft--;
      memBusy     = (beatsLeft != 0);
    end
  end

  // check each returned word first, then note a newly taken address
  always @(posedge clk) begin
    if (rst_n) begin
      if (dataOk_o) begin
        checkCount++;
        assert (rdData_o == refWord(takenAddr)) else begin
          errCount++;
          $display("MISMATCH at %0t: address %h returned %h, expected %h",
                   $time, takenAddr, rdData_o, refWord(takenAddr));
        end
      end
      if (addrOk_o && valid_i && stall_n_i && (addr_i != takenAddr)) begin
        takenAddr = addr_i;
      end
    end
  end

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt >= MaxCycles) begin
      $display("timeout after %0d cycles, the DUT stopped answering", MaxCycles);
      $display("Checks failed");
      $finish;
    end
  end

  // present one address, optionally stalled first, and wait for its word
  task automatic runFetch(input logic [`ADDR_W-1:0] a, input int stallCycles,
                          input bit miss, input bit uncached);
    int                 reqBefore;
    int                 lat;
    logic [`ADDR_W-1:0] expAddr;
    logic [7:0]         expLen;
    reqBefore = reqCount;
    expAddr   = uncached ? a : {a[`ADDR_W-1:5], 5'b00000};
    expLen    = uncached ? 8'd0 : 8'd3;
    addr_i    <= a;
    valid_i   <= 1'b1;
    stall_n_i <= (stallCycles == 0);
    repeat (stallCycles) begin
      @(posedge clk);
      checkCount++;
      assert (!dataOk_o && !dataNotOk_o) else begin
        errCount++;
        $display("address %h was taken while stall_n_i was low", a);
      end
    end
    stall_n_i <= 1'b1;
    @(posedge clk);
    while (!addrOk_o) @(posedge clk);
    lat = 0;
    // every cycle after the take either returns the word or flags the miss
    do begin
      @(posedge clk);
      lat++;
      checkCount++;
      assert (dataOk_o || dataNotOk_o) else begin
        errCount++;
        $display("dataNotOk_o was low while %h was still outstanding at %0t", a, $time);
      end
    end while (!dataOk_o);
    valid_i <= 1'b0;
    checkCount++;
    if (miss) begin
      assert (reqCount == reqBefore + 1) else begin
        errCount++;
        $display("miss at %h made %0d memory requests instead of one", a, reqCount - reqBefore);
      end
      assert (lastReqLen == expLen && lastReqAddr == expAddr) else begin
        errCount++;
        $display("MISMATCH at %0t: request %h len %0d, expected %h len %0d",
                 $time, lastReqAddr, lastReqLen, expAddr, expLen);
      end
      if (!uncached) begin
        fillCount++;
      end
    end else begin
      assert (lat == 1 && reqCount == reqBefore) else begin
        errCount++;
        $display("hit at %h took %0d cycles and %0d memory requests", a, lat,
                 reqCount - reqBefore);
      end
    end
  endtask

  task automatic endTest(input int num, input string name);
    repeat (2) @(posedge clk);
    #1;
    if (errCount == errAtStart) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errCount - errAtStart);
    end
    errAtStart = errCount;
    @(posedge clk);
  endtask

  initial begin
    int                 pWay;
    int                 rWay;
    logic [`ADDR_W-1:0] evicted;
    logic [`ADDR_W-1:0] kept;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    runFetch(LineL, 0, 1'b1, 1'b0);
    endTest(1, "cold miss");
    runFetch(LineL + 8, 0, 1'b0, 1'b0);
    runFetch(LineL + 16, 0, 1'b0, 1'b0);
    runFetch(LineL + 24, 0, 1'b0, 1'b0);
    endTest(2, "hits in filled line");
    runFetch(UncAddr, 0, 1'b1, 1'b1);
    runFetch(LineL + 24, 0, 1'b0, 1'b0);
    runFetch(UncAddr, 0, 1'b1, 1'b1);
    endTest(3, "uncached single beat");
    // victim flips on every line fill, way 1 after reset
    pWay = fillCount % 2;
    runFetch(LineP, 0, 1'b1, 1'b0);
    runFetch(LineQ, 0, 1'b1, 1'b0);
    runFetch(LineP + 8, 0, 1'b0, 1'b0);
    runFetch(LineQ + 16, 0, 1'b0, 1'b0);
    rWay = fillCount % 2;
    runFetch(LineR, 0, 1'b1, 1'b0);
    evicted = (rWay == pWay) ? LineP : LineQ;
    kept    = (rWay == pWay) ? LineQ : LineP;
    runFetch(kept + 24, 0, 1'b0, 1'b0);
    runFetch(LineR + 8, 0, 1'b0, 1'b0);
    runFetch(evicted + 8, 0, 1'b1, 1'b0);
    endTest(4, "two ways and victim toggle");
    runFetch(LineL + 16, 0, 1'b0, 1'b0);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    @(posedge clk);
    runFetch(LineL + 8, 0, 1'b1, 1'b0);
    runFetch(LineL + 16, 0, 1'b0, 1'b0);
    endTest(5, "flush");
    runFetch(LineS, 5, 1'b1, 1'b0);
    runFetch(LineS + 8, 3, 1'b0, 1'b0);
    endTest(6, "stall");
    $display("%0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== icacheTop.f ====
+incdir+common
common/icachePkg.sv
verilog/fetchReqLatch.sv
icache/icacheCtrl.sv
icache/icacheTagStore.sv
icache/icacheDataStore.sv
verilog/refillBuffer.sv
verilog/icacheTop.sv
verification/icacheProps.sv
verification/icacheTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f icacheTop.f --top-module icacheTb -o simIcache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/simIcache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
